//--- sources.f
+incdir+testbench
hdl/plic_pkg.sv
hdl/plic_skid_buffer.sv
hdl/plic_bus_ctrl.sv
hdl/plic_gateway.sv
hdl/plic_target.sv
hdl/plic_top.sv
testbench/tb_plic_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PLIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module tb_plic_top; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_plic_top)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- testbench/tb_plic_model.svh
/* reference model of the PLIC register state, gateway and arbitration, plus TileLink
   access tasks. assumes word aligned addresses and a caller that sits on a falling edge */
`ifndef TB_PLIC_MODEL_SVH
`define TB_PLIC_MODEL_SVH

logic [2:0]  m_prio [1:15];
logic [15:1] m_en [0:1];
logic [2:0]  m_th [0:1];
logic [15:1] m_pend;
logic [15:1] m_fly;

function automatic bit is_mapped(input logic [21:0] addr);
    if (addr >= 22'h4 && addr <= 22'h3c) begin
        return 1'b1;
    end
    return addr == 22'h1000 || addr == 22'h2000 || addr == 22'h2080
        || addr == 22'h200000 || addr == 22'h200004
        || addr == 22'h201000 || addr == 22'h201004;
endfunction

function automatic bit is_claim_addr(input logic [21:0] addr);
    return addr == 22'h200004 || addr == 22'h201004;
endfunction

// highest priority above threshold wins and ties go to the lowest id
function automatic logic [3:0] best_of(input int ctx);
    logic [2:0] top;
    bit         found;
    top   = '0;
    found = 1'b0;
    for (int i = 1; i <= 15; i++) begin
        if (m_pend[i] && m_en[ctx][i] && m_prio[i] > m_th[ctx]) begin
            if (!found || m_prio[i] > top) begin
                top = m_prio[i];
            end
            found = 1'b1;
        end
    end
    for (int i = 1; i <= 15; i++) begin
        if (found && m_pend[i] && m_en[ctx][i] && m_prio[i] == top && m_prio[i] > m_th[ctx]) begin
            return 4'(i);
        end
    end
    return 4'd0;
endfunction

function automatic logic [31:0] word_of(input logic [21:0] addr);
    logic [31:0] w;
    w = '0;
    if (addr >= 22'h4 && addr <= 22'h3c) begin
        w[2:0] = m_prio[addr[5:2]];
    end else if (addr == 22'h1000) begin
        w[15:1] = m_pend;
    end else if (addr == 22'h2000 || addr == 22'h2080) begin
        w[15:1] = m_en[addr == 22'h2080];
    end else if (addr == 22'h200000 || addr == 22'h201000) begin
        w[2:0] = m_th[addr == 22'h201000];
    end else if (is_claim_addr(addr)) begin
        w[3:0] = best_of(int'(addr == 22'h201004));
    end
    return w;
endfunction

function automatic void apply_write(input logic [21:0] addr, input logic [3:0] mask,
                                    input logic [31:0] data);
    logic [31:0] w;
    w = word_of(addr);
    for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
            w[8*b +: 8] = data[8*b +: 8];
        end
    end
    if (addr >= 22'h4 && addr <= 22'h3c) begin
        m_prio[addr[5:2]] = w[2:0];
    end else if (addr == 22'h2000 || addr == 22'h2080) begin
        m_en[addr == 22'h2080] = w[15:1];
    end else if (addr == 22'h200000 || addr == 22'h201000) begin
        m_th[addr == 22'h201000] = w[2:0];
    end else if (is_claim_addr(addr) && data[3:0] != 4'd0) begin
        // complete of an id not in flight changes nothing
        m_fly[data[3:0]] = 1'b0;
    end
endfunction

// level sources latch into pending unless in flight
function automatic void latch_pending(input logic [14:0] lines);
    m_pend = m_pend | (lines & ~m_fly);
endfunction

task automatic send(input logic [2:0] op, input logic [3:0] size, input logic [21:0] addr,
                    input logic [3:0] mask, input logic [31:0] data);
    plic_pkg::plic_rsp_t e;
    bit                  den;
    logic [3:0]          id;
    int                  cnt;
    den = !(op == 3'd0 || op == 3'd1 || op == 3'd4) || size > 4'd2 || !is_mapped(addr);
    a_opcode  = op;
    a_size    = size;
    a_source  = 4'($urandom_range(15));
    a_address = addr;
    a_mask    = mask;
    a_data    = data;
    a_valid   = 1'b1;
    cnt = 0;
    while (!a_ready) begin
        @(negedge plic_clock);
        cnt++;
        if (cnt > 200) begin
            abort_run("timeout: a_ready stayed low for 200 cycles");
        end
    end
    e.opcode = (op == 3'd4) ? plic_pkg::access_ack_data : plic_pkg::access_ack;
    e.size   = size;
    e.source = a_source;
    e.denied = den;
    e.data   = (op == 3'd4 && !den) ? word_of(addr) : 32'h0;
    exp_q.push_back(e);
    if (!den && op != 3'd4) begin
        apply_write(addr, mask, data);
    end else if (!den && is_claim_addr(addr)) begin
        id = best_of(int'(addr == 22'h201004));
        if (id != 4'd0) begin
            m_pend[id] = 1'b0;
            m_fly[id]  = 1'b1;
        end
    end
    @(negedge plic_clock);
    a_valid = 1'b0;
endtask

task automatic drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0) begin
        @(negedge plic_clock);
        cnt++;
        if (cnt > 200) begin
            abort_run("timeout: responses missing after 200 cycles");
        end
    end
endtask

`endif

//--- testbench/tb_plic_top.sv
/* random testbench for plic_top with a fixed seed; d_ready toggles randomly all run long.
   inputs change on the falling edge, responses are checked in order on the rising edge */
`timescale 1ns/1ps
`default_nettype none

module tb_plic_top;

    logic        plic_clock = 1'b0;
    logic        rst_n;
    logic [2:0]  a_opcode;
    logic [3:0]  a_size;
    logic [3:0]  a_source;
    logic [21:0] a_address;
    logic [3:0]  a_mask;
    logic [31:0] a_data;
    logic        a_valid;
    logic        a_ready;
    logic [2:0]  d_opcode;
    logic [3:0]  d_size;
    logic [3:0]  d_source;
    logic        d_denied;
    logic [31:0] d_data;
    logic        d_valid;
    logic        d_ready = 1'b0;
    logic [14:0] int_in;
    logic        hart0_meip;
    logic        hart0_seip;

    int                  errors = 0;
    string               test_name = "reset";
    plic_pkg::plic_rsp_t exp_q[$];

    `include "tb_plic_model.svh"

    plic_top #(.TL_RS(4)) i_plic_top (.*);

    always #2 plic_clock = ~plic_clock;

    always @(negedge plic_clock) begin
        d_ready <= ($urandom_range(3) != 0);
    end

    always @(posedge plic_clock) begin : check_rsp
        plic_pkg::plic_rsp_t e;
        plic_pkg::plic_rsp_t act;
        if (rst_n && d_valid && d_ready) begin
            act = {d_opcode, d_size, d_source, d_denied, d_data};
            if (exp_q.size() == 0) begin
                errors++;
                $display("response seen with no request outstanding in %s", test_name);
            end else begin
                e = exp_q.pop_front();
                if (act !== e) begin
                    errors++;
                    $display("[ERROR] %s: expected %h, actual %h", test_name, e, act);
                end
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: %0d", errors);
        $display("sim failed");
        $finish;
    endtask

    task automatic settle();
        repeat (4) @(negedge plic_clock);
        latch_pending(int_in);
    endtask

    function automatic logic [21:0] random_reg();
        case ($urandom_range(2))
            0:       return 22'(4 * $urandom_range(1, 15));
            1:       return $urandom_range(1) ? 22'h2080 : 22'h2000;
            default: return $urandom_range(1) ? 22'h201000 : 22'h200000;
        endcase
    endfunction

    task automatic read_all();
        for (int i = 1; i <= 15; i++) begin
            send(3'd4, 4'd2, 22'(4 * i), 4'hf, 32'h0);
        end
        send(3'd4, 4'd2, 22'h2000, 4'hf, 32'h0);
        send(3'd4, 4'd2, 22'h2080, 4'hf, 32'h0);
        send(3'd4, 4'd2, 22'h200000, 4'hf, 32'h0);
        send(3'd4, 4'd2, 22'h201000, 4'hf, 32'h0);
        send(3'd4, 4'd2, 22'h1000, 4'hf, 32'h0);
        drain();
    endtask

    initial begin : run
        logic [21:0] addr;
        logic [21:0] bad [0:7];
        logic [3:0]  id;
        logic [3:0]  wrong;
        void'($urandom(32'h1feeffa3));
        bad = '{22'h0, 22'h40, 22'h1004, 22'h2004, 22'h2100, 22'h200008, 22'h202000,
                22'h3ffffc};
        for (int i = 1; i <= 15; i++) begin
            m_prio[i] = '0;
        end
        m_en = '{15'h0, 15'h0};
        m_th = '{3'h0, 3'h0};
        m_pend = '0;
        m_fly = '0;
        rst_n = 1'b0;
        a_opcode = '0;
        a_size = '0;
        a_source = '0;
        a_address = '0;
        a_mask = '0;
        a_data = '0;
        a_valid = 1'b0;
        int_in = '0;
        repeat (16) @(negedge plic_clock);
        rst_n = 1'b1;
        @(negedge plic_clock);

        // a_ready, d_valid, meip and seip right after reset
        if ({a_ready, d_valid, hart0_meip, hart0_seip} !== 4'b1000) begin
            errors++;
            $display("[ERROR] %s: expected %b, actual %b", test_name, 4'b1000,
                     {a_ready, d_valid, hart0_meip, hart0_seip});
        end
        read_all();

        test_name = "round_trip";
        for (int n = 0; n < 40; n++) begin
            addr = random_reg();
            send($urandom_range(1) ? 3'd1 : 3'd0, 4'd2, addr, 4'($urandom_range(15)), $urandom);
            send(3'd4, 4'd2, addr, 4'hf, 32'h0);
            drain();
        end
        read_all();

        test_name = "denied";
        foreach (bad[k]) begin
            send(3'd4, 4'd2, bad[k], 4'hf, 32'h0);
            send(3'd0, 4'd2, bad[k], 4'hf, $urandom);
        end
        send(3'd4, 4'd3, 22'h4, 4'hf, 32'h0);
        send(3'd0, 4'd3, 22'h4, 4'hf, 32'h7);
        send(3'd2, 4'd2, 22'h4, 4'hf, 32'h7);
        send(3'd7, 4'd2, 22'h2000, 4'hf, 32'hffff);
        drain();
        read_all();

        test_name = "back_pressure";
        for (int n = 0; n < 60; n++) begin
            send($urandom_range(1) ? 3'd4 : 3'd0, 4'd2, random_reg(), 4'hf, $urandom);
        end
        drain();

        test_name = "interrupt_lines";
        for (int n = 0; n < 12; n++) begin
            int_in = 15'($urandom);
            for (int k = 0; k < 4; k++) begin
                send(3'd0, 4'd2, 22'(4 * $urandom_range(1, 15)), 4'h1, $urandom);
            end
            send(3'd0, 4'd2, 22'h2000, 4'hf, $urandom);
            send(3'd0, 4'd2, 22'h2080, 4'hf, $urandom);
            send(3'd0, 4'd2, 22'h200000, 4'h1, $urandom);
            send(3'd0, 4'd2, 22'h201000, 4'h1, $urandom);
            drain();
            settle();
            if (hart0_meip !== (best_of(0) != 4'd0)) begin
                errors++;
                $display("[ERROR] %s meip: expected %b, actual %b", test_name,
                         best_of(0) != 4'd0, hart0_meip);
            end
            if (hart0_seip !== (best_of(1) != 4'd0)) begin
                errors++;
                $display("[ERROR] %s seip: expected %b, actual %b", test_name,
                         best_of(1) != 4'd0, hart0_seip);
            end
        end

        test_name = "claim_complete";
        for (int n = 0; n < 16; n++) begin
            int_in = 15'($urandom);
            settle();
            addr = $urandom_range(1) ? 22'h201004 : 22'h200004;
            id = best_of(int'(addr == 22'h201004));
            send(3'd4, 4'd2, addr, 4'hf, 32'h0);
            drain();
            settle();
            // source held high stays blocked while in flight
            send(3'd4, 4'd2, 22'h1000, 4'hf, 32'h0);
            wrong = 4'($urandom_range(15));
            while (wrong != 4'd0 && m_fly[wrong]) begin
                wrong = wrong - 4'd1;
            end
            send(3'd0, 4'd2, addr, 4'hf, {28'h0, wrong});
            drain();
            settle();
            send(3'd4, 4'd2, 22'h1000, 4'hf, 32'h0);
            send(3'd0, 4'd2, addr, 4'hf, {28'h0, id});
            drain();
            settle();
            send(3'd4, 4'd2, 22'h1000, 4'hf, 32'h0);
            drain();
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/plic_top.sv
/* PLIC for a single hart as a TileLink-UL slave, context 0 drives meip and context 1 seip.
   a_param and a_corrupt are not taken; TL_RS must equal plic_pkg::SOURCE_W */
`timescale 1ns/1ps
`default_nettype none

module plic_top #(
    parameter int TL_RS = 4
) (
    input  wire logic                         plic_clock,
    input  wire logic                         rst_n,

    input  wire logic [2:0]                   a_opcode,
    input  wire logic [3:0]                   a_size,
    input  wire logic [TL_RS-1:0]             a_source,
    input  wire logic [21:0]                  a_address,
    input  wire logic [3:0]                   a_mask,
    input  wire logic [31:0]                  a_data,
    input  wire logic                         a_valid,
    output logic                              a_ready,

    output logic [2:0]                        d_opcode,
    output logic [3:0]                        d_size,
    output logic [TL_RS-1:0]                  d_source,
    output logic                              d_denied,
    output logic [31:0]                       d_data,
    output logic                              d_valid,
    input  wire logic                         d_ready,

    input  wire logic [plic_pkg::NUM_SRC-1:0] int_in,
    output logic                              hart0_meip,
    output logic                              hart0_seip
);

    localparam int NUM_SRC = plic_pkg::NUM_SRC;
    localparam int PRIO_W  = plic_pkg::PRIO_W;
    localparam int ID_W    = plic_pkg::ID_W;

    plic_pkg::plic_req_t       a_req;
    plic_pkg::plic_req_t       req;
    plic_pkg::plic_rsp_t       d_rsp;
    logic                      req_valid;
    logic                      req_take;
    logic [NUM_SRC-1:0]        pending;
    logic [NUM_SRC*PRIO_W-1:0] prio;
    logic [NUM_SRC-1:0]        enable_m;
    logic [NUM_SRC-1:0]        enable_s;
    logic [PRIO_W-1:0]         thresh_m;
    logic [PRIO_W-1:0]         thresh_s;
    logic [ID_W-1:0]           best_id_m;
    logic [ID_W-1:0]           best_id_s;
    logic                      claim_stb;
    logic [ID_W-1:0]           claim_id;
    logic                      complete_stb;
    logic [ID_W-1:0]           complete_id;

    assign a_req    = {a_source, a_size, a_address, a_mask, a_data, a_opcode};
    assign d_opcode = d_rsp.opcode;
    assign d_size   = d_rsp.size;
    assign d_source = d_rsp.source;
    assign d_denied = d_rsp.denied;
    assign d_data   = d_rsp.data;

    plic_skid_buffer #(
        .WIDTH($bits(plic_pkg::plic_req_t))
    ) i_skid_buffer (
        .plic_clock(plic_clock),
        .rst_n     (rst_n),
        .in_valid  (a_valid),
        .in_data   (a_req),
        .in_ready  (a_ready),
        .out_valid (req_valid),
        .out_data  (req),
        .out_take  (req_take)
    );

    plic_bus_ctrl #(
        .TL_RS(TL_RS)
    ) i_bus_ctrl (
        .plic_clock  (plic_clock),
        .rst_n       (rst_n),
        .req         (req),
        .req_valid   (req_valid),
        .req_take    (req_take),
        .d_rsp       (d_rsp),
        .d_valid     (d_valid),
        .d_ready     (d_ready),
        .pending     (pending),
        .best_id_m   (best_id_m),
        .best_id_s   (best_id_s),
        .prio        (prio),
        .enable_m    (enable_m),
        .enable_s    (enable_s),
        .thresh_m    (thresh_m),
        .thresh_s    (thresh_s),
        .claim_stb   (claim_stb),
        .claim_id    (claim_id),
        .complete_stb(complete_stb),
        .complete_id (complete_id)
    );

    plic_gateway i_gateway (
        .plic_clock  (plic_clock),
        .rst_n       (rst_n),
        .int_in      (int_in),
        .claim_stb   (claim_stb),
        .claim_id    (claim_id),
        .complete_stb(complete_stb),
        .complete_id (complete_id),
        .pending     (pending)
    );

    // machine mode context
    plic_target i_target_m (
        .plic_clock(plic_clock),
        .rst_n     (rst_n),
        .pending   (pending),
        .enable    (enable_m),
        .prio      (prio),
        .thresh    (thresh_m),
        .best_id   (best_id_m),
        .irq       (hart0_meip)
    );

    // supervisor context
    plic_target i_target_s (
        .plic_clock(plic_clock),
        .rst_n     (rst_n),
        .pending   (pending),
        .enable    (enable_s),
        .prio      (prio),
        .thresh    (thresh_s),
        .best_id   (best_id_s),
        .irq       (hart0_seip)
    );

endmodule

`default_nettype wire

//--- hdl/plic_target.sv
/* per-context arbiter, highest priority above threshold wins and ties go to the lower id.
   best_id and irq are registered, one cycle behind the inputs */
`timescale 1ns/1ps
`default_nettype none

module plic_target (
    input  wire logic                                     plic_clock,
    input  wire logic                                     rst_n,
    input  wire logic [plic_pkg::NUM_SRC-1:0]             pending,
    input  wire logic [plic_pkg::NUM_SRC-1:0]             enable,
    input  wire logic [plic_pkg::NUM_SRC*plic_pkg::PRIO_W-1:0] prio,
    input  wire logic [plic_pkg::PRIO_W-1:0]              thresh,
    output logic [plic_pkg::ID_W-1:0]                     best_id,
    output logic                                          irq
);

    localparam int NUM_SRC = plic_pkg::NUM_SRC;
    localparam int PRIO_W  = plic_pkg::PRIO_W;
    localparam int ID_W    = plic_pkg::ID_W;

    logic [ID_W-1:0]   best_c;
    logic [PRIO_W-1:0] best_prio;

    always_comb begin
        // running best starts at the threshold, so a winner must be strictly above it
        best_c    = '0;
        best_prio = thresh;
        // ascending scan with a strict compare keeps the lower id on a tie
        for (int i = 1; i <= NUM_SRC; i++) begin
            if (pending[i-1] && enable[i-1] && prio[(i-1)*PRIO_W +: PRIO_W] > best_prio) begin
                best_c    = ID_W'(i);
                best_prio = prio[(i-1)*PRIO_W +: PRIO_W];
            end
        end
    end

    always_ff @(posedge plic_clock) begin
        if (!rst_n) begin
            best_id <= '0;
            irq     <= 1'b0;
        end else begin
            best_id <= best_c;
            irq     <= best_c != '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/plic_gateway.sv
/* level gateway per source; pending latches a high level and the source is blocked
   from claim until a complete of the same id. bit 0 of int_in is source 1 */
`timescale 1ns/1ps
`default_nettype none

module plic_gateway (
    input  wire logic                         plic_clock,
    input  wire logic                         rst_n,
    input  wire logic [plic_pkg::NUM_SRC-1:0] int_in,
    input  wire logic                         claim_stb,
    input  wire logic [plic_pkg::ID_W-1:0]    claim_id,
    input  wire logic                         complete_stb,
    input  wire logic [plic_pkg::ID_W-1:0]    complete_id,
    output logic [plic_pkg::NUM_SRC-1:0]      pending
);

    localparam int NUM_SRC = plic_pkg::NUM_SRC;

    logic [NUM_SRC-1:0] in_flight;
    logic [NUM_SRC:0]   claim_dec;
    logic [NUM_SRC:0]   done_dec;
    logic [NUM_SRC:0]   pend_ext;

    // one-hot by id, bit 0 stands for the unused id 0
    assign claim_dec = {{NUM_SRC{1'b0}}, claim_stb} << claim_id;
    assign done_dec  = {{NUM_SRC{1'b0}}, complete_stb} << complete_id;
    assign pend_ext  = {pending, 1'b0};

    always_ff @(posedge plic_clock) begin
        if (!rst_n) begin
            pending   <= '0;
            in_flight <= '0;
        end else begin
            // a claim beats a new level on the same source
            pending   <= (pending | (int_in & ~in_flight)) & ~claim_dec[NUM_SRC:1];
            // completes for ids not in flight clear nothing
            in_flight <= (in_flight & ~done_dec[NUM_SRC:1]) | claim_dec[NUM_SRC:1];
        end
    end

    // the controller only claims an id the target saw as pending
    a_claim_pending: assert property (@(posedge plic_clock) disable iff (!rst_n)
        claim_stb |-> claim_id != '0 && pend_ext[claim_id]);

endmodule

`default_nettype wire

//--- hdl/plic_bus_ctrl.sv
/* register file and TileLink-UL request decode; single beat only, size above 2 is denied.
   a claim read waits two cycles after any write or claim so the target ids have settled */
`timescale 1ns/1ps
`default_nettype none

module plic_bus_ctrl #(
    parameter int TL_RS = 4
) (
    input  wire logic                                     plic_clock,
    input  wire logic                                     rst_n,
    input  wire plic_pkg::plic_req_t                      req,
    input  wire logic                                     req_valid,
    output logic                                          req_take,
    output plic_pkg::plic_rsp_t                           d_rsp,
    output logic                                          d_valid,
    input  wire logic                                     d_ready,
    input  wire logic [plic_pkg::NUM_SRC-1:0]             pending,
    input  wire logic [plic_pkg::ID_W-1:0]                best_id_m,
    input  wire logic [plic_pkg::ID_W-1:0]                best_id_s,
    output logic [plic_pkg::NUM_SRC*plic_pkg::PRIO_W-1:0] prio,
    output logic [plic_pkg::NUM_SRC-1:0]                  enable_m,
    output logic [plic_pkg::NUM_SRC-1:0]                  enable_s,
    output logic [plic_pkg::PRIO_W-1:0]                   thresh_m,
    output logic [plic_pkg::PRIO_W-1:0]                   thresh_s,
    output logic                                          claim_stb,
    output logic [plic_pkg::ID_W-1:0]                     claim_id,
    output logic                                          complete_stb,
    output logic [plic_pkg::ID_W-1:0]                     complete_id
);

    localparam int NUM_SRC = plic_pkg::NUM_SRC;
    localparam int PRIO_W  = plic_pkg::PRIO_W;
    localparam int ID_W    = plic_pkg::ID_W;

    logic                is_get;
    logic                is_put;
    logic                hit_prio;
    logic                hit_pend;
    logic                hit_en;
    logic                hit_ctx;
    logic                is_claim;
    logic                denied;
    logic                fire;
    logic                claim_wait;
    logic                en_ctx;
    logic                tgt_ctx;
    logic [ID_W-1:0]     src_idx;
    logic [ID_W-1:0]     ctx_best;
    int                  prio_lsb;
    logic [31:0]         cur_word;
    logic [31:0]         wr_word;
    logic [1:0]          hold_cnt;
    plic_pkg::plic_rsp_t rsp;

    // the request and response structs carry SOURCE_W bits of source id
    if (TL_RS != plic_pkg::SOURCE_W) begin : g_bad_source_width
        $error("TL_RS must equal plic_pkg::SOURCE_W");
    end

    always_comb begin
        is_get   = req.opcode == plic_pkg::get;
        is_put   = req.opcode == plic_pkg::put_full || req.opcode == plic_pkg::put_partial;
        src_idx  = req.address[5:2];
        en_ctx   = req.address[7];
        tgt_ctx  = req.address[12];
        // priority 0 does not exist
        hit_prio = req.address[21:6] == plic_pkg::PRIO_BASE[21:6] && src_idx != '0;
        hit_pend = req.address[21:2] == plic_pkg::PEND_ADDR[21:2];
        hit_en   = req.address[21:8] == plic_pkg::ENABLE_BASE[21:8] && req.address[6:2] == '0;
        hit_ctx  = req.address[21:13] == plic_pkg::CTX_BASE[21:13] && req.address[11:3] == '0;
        is_claim = hit_ctx && req.address[2];
        denied   = !(is_get || is_put) || req.size > 4'd2
                   || !(hit_prio || hit_pend || hit_en || hit_ctx);
        ctx_best = tgt_ctx ? best_id_s : best_id_m;
        prio_lsb = hit_prio ? (int'(src_idx) - 1) * PRIO_W : 0;

        // current image of the addressed word, also the base for masked writes
        cur_word = '0;
        if (hit_prio) begin
            cur_word[PRIO_W-1:0] = prio[prio_lsb +: PRIO_W];
        end else if (hit_pend) begin
            cur_word[NUM_SRC:1] = pending;
        end else if (hit_en) begin
            cur_word[NUM_SRC:1] = en_ctx ? enable_s : enable_m;
        end else if (hit_ctx && !req.address[2]) begin
            cur_word[PRIO_W-1:0] = tgt_ctx ? thresh_s : thresh_m;
        end else if (is_claim) begin
            cur_word[ID_W-1:0] = ctx_best;
        end

        // prio and threshold live in lane 0, so a plain byte merge covers every field
        for (int b = 0; b < 4; b++) begin
            wr_word[8*b +: 8] = req.mask[b] ? req.data[8*b +: 8] : cur_word[8*b +: 8];
        end
    end

    assign claim_wait = req_valid && is_get && is_claim && hold_cnt != 2'd0;
    assign req_take   = (!d_valid || d_ready) && !claim_wait;
    assign fire       = req_valid && req_take;

    assign claim_stb    = fire && is_get && is_claim && !denied && ctx_best != '0;
    assign claim_id     = ctx_best;
    assign complete_stb = fire && is_put && is_claim && !denied;
    assign complete_id  = req.data[ID_W-1:0];

    always_comb begin
        rsp.opcode = is_get ? plic_pkg::access_ack_data : plic_pkg::access_ack;
        rsp.size   = req.size;
        rsp.source = req.source;
        rsp.denied = denied;
        rsp.data   = (is_get && !denied) ? cur_word : '0;
    end

    always_ff @(posedge plic_clock) begin
        if (!rst_n) begin
            d_valid  <= 1'b0;
            hold_cnt <= '0;
            prio     <= '0;
            enable_m <= '0;
            enable_s <= '0;
            thresh_m <= '0;
            thresh_s <= '0;
        end else begin
            if (fire) begin
                d_valid <= 1'b1;
            end else if (d_ready) begin
                d_valid <= 1'b0;
            end

            if (fire && !denied && (is_put || claim_stb)) begin
                hold_cnt <= 2'd2;
            end else if (hold_cnt != 2'd0) begin
                hold_cnt <= hold_cnt - 2'd1;
            end

            // writes to the pending word are acked and dropped
            if (fire && is_put && !denied) begin
                if (hit_prio) begin
                    prio[prio_lsb +: PRIO_W] <= wr_word[PRIO_W-1:0];
                end
                if (hit_en && en_ctx) begin
                    enable_s <= wr_word[NUM_SRC:1];
                end
                if (hit_en && !en_ctx) begin
                    enable_m <= wr_word[NUM_SRC:1];
                end
                if (hit_ctx && !req.address[2] && tgt_ctx) begin
                    thresh_s <= wr_word[PRIO_W-1:0];
                end
                if (hit_ctx && !req.address[2] && !tgt_ctx) begin
                    thresh_m <= wr_word[PRIO_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge plic_clock) begin
        if (fire) begin
            d_rsp <= rsp;
        end
    end

    a_claim_xor_complete: assert property (@(posedge plic_clock) disable iff (!rst_n)
        !(claim_stb && complete_stb));

endmodule

`default_nettype wire

//--- hdl/plic_skid_buffer.sv
/* two-slot valid/ready buffer, in_ready is registered and never follows out_take
   combinationally. out_data holds while out_valid is high and not taken */
`timescale 1ns/1ps
`default_nettype none

module plic_skid_buffer #(
    parameter int WIDTH = 8
) (
    input  wire logic             plic_clock,
    input  wire logic             rst_n,
    input  wire logic             in_valid,
    input  wire logic [WIDTH-1:0] in_data,
    output logic                  in_ready,
    output logic                  out_valid,
    output logic [WIDTH-1:0]      out_data,
    input  wire logic             out_take
);

    logic             skid_valid;
    logic [WIDTH-1:0] skid_data;
    logic             accept;

    assign accept   = in_valid && in_ready;
    // only the skid slot decides whether a new beat fits
    assign in_ready = !skid_valid;

    always_ff @(posedge plic_clock) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!out_valid || out_take) begin
            // main slot frees up, skid entry goes first
            out_valid  <= skid_valid || accept;
            skid_valid <= 1'b0;
        end else if (accept) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge plic_clock) begin
        if (!out_valid || out_take) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (accept && out_valid && !out_take) begin
            skid_data <= in_data;
        end
    end

    a_out_stable: assert property (@(posedge plic_clock) disable iff (!rst_n)
        out_valid && !out_take |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- hdl/plic_pkg.sv
/* shared TileLink-UL types and PLIC address map for one hart with 15 level sources.
   SOURCE_W must match the TL_RS parameter given to plic_top */
`default_nettype none

package plic_pkg;

    // TileLink source id width, plic_top passes it down as TL_RS
    parameter int SOURCE_W = 4;
    parameter int NUM_SRC  = 15;
    parameter int PRIO_W   = 3;
    // id 0 means no interrupt
    parameter int ID_W     = $clog2(NUM_SRC + 1);

    // 4 bytes per source id
    parameter logic [21:0] PRIO_BASE   = 22'h000000;
    parameter logic [21:0] PEND_ADDR   = 22'h001000;
    // 0x80 per context
    parameter logic [21:0] ENABLE_BASE = 22'h002000;
    // 0x1000 per context, threshold at +0 and claim/complete at +4
    parameter logic [21:0] CTX_BASE    = 22'h200000;

    typedef enum logic [2:0] {
        put_full    = 3'd0,
        put_partial = 3'd1,
        get         = 3'd4
    } tl_a_op_e;

    typedef enum logic [2:0] {
        access_ack      = 3'd0,
        access_ack_data = 3'd1
    } tl_d_op_e;

    typedef struct packed {
        logic [SOURCE_W-1:0] source;
        logic [3:0]          size;
        logic [21:0]         address;
        logic [3:0]          mask;
        logic [31:0]         data;
        tl_a_op_e            opcode;
    } plic_req_t;

    typedef struct packed {
        tl_d_op_e            opcode;
        logic [3:0]          size;
        logic [SOURCE_W-1:0] source;
        logic                denied;
        logic [31:0]         data;
    } plic_rsp_t;

endpackage

`default_nettype wire
